/* Bender.yml */
package:
  name: uart_link_tester

sources:
  - common/lt_pkg.sv
  - uart/uart_tx.sv
  - uart/uart_rx.sv
  - rtl/pattern_gen.sv
  - rtl/loopback_lane.sv
  - rtl/error_tally.sv
  - rtl/lt_regs.sv
  - rtl/uart_link_tester.sv
  - target: simulation
    files:
      - dv/tb_uart_link_tester.sv

/* common/lt_pkg.sv */
/*
  Shared constants and types of the UART loopback link tester.
  The frame is fixed at 8E1 with one start bit, and the bit time is a
  whole number of clock cycles. Register offsets are byte addresses.
*/
package lt_pkg;

    localparam int NUM_LANES   = 4;
    localparam int BIT_CYCLES  = 16;
    localparam int FRAME_BITS  = 11;
    localparam int QUEUE_DEPTH = 2;

    // Register map
    localparam logic [7:0] REG_CTRL     = 8'h00;
    localparam logic [7:0] REG_SEED     = 8'h04;
    localparam logic [7:0] REG_ROUNDS   = 8'h08;
    localparam logic [7:0] REG_ERR_BASE = 8'h10;

    typedef logic [7:0]           byte_t;
    typedef logic [NUM_LANES-1:0] lane_mask_t;
    typedef logic [15:0]          count_t;
    typedef logic [7:0]           axil_addr_t;
    typedef logic [31:0]          axil_data_t;

    typedef enum logic [2:0] {
        TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP
    } tx_state_t;

    typedef enum logic [2:0] {
        RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP
    } rx_state_t;

endpackage

/* dv/tb_uart_link_tester.sv */
/*
  Testbench of the UART loopback link tester.
  Each ser_out is looped back to its ser_in through an XOR with a fault bit.
  A fault flips exactly one data bit of a frame for one bit time.
  Per-lane monitors decode ser_out, and the main process checks the counters.
  The run stops at the first mismatch or when the cycle limit is reached.
*/
`timescale 1ns/100ps

module tb_uart_link_tester;

    localparam int N_CLEAN        = 18;
    localparam int N_FAULT        = 10;
    localparam int N_RESUME       = 3;
    localparam int MAX_FRAMES     = 18;
    localparam int FRAME_CYCLES   = lt_pkg::FRAME_BITS * lt_pkg::BIT_CYCLES + 1;
    localparam int TIMEOUT_CYCLES = 3 * (N_CLEAN + N_FAULT + N_RESUME) * FRAME_CYCLES;

    logic               clk;
    logic               rst;
    lt_pkg::axil_addr_t aw_addr;
    logic               aw_valid;
    logic               aw_ready;
    lt_pkg::axil_data_t w_data;
    logic               w_valid;
    logic               w_ready;
    logic [1:0]         b_resp;
    logic               b_valid;
    logic               b_ready;
    lt_pkg::axil_addr_t ar_addr;
    logic               ar_valid;
    logic               ar_ready;
    lt_pkg::axil_data_t r_data;
    logic [1:0]         r_resp;
    logic               r_valid;
    logic               r_ready;
    lt_pkg::lane_mask_t ser_out;
    lt_pkg::lane_mask_t ser_in;
    lt_pkg::lane_mask_t fault;

    logic [15:0]   lfsr;
    lt_pkg::byte_t cur_seed;
    int            run_len;
    int            exp_rounds;
    int            cycle_count;
    int            frame_idx [lt_pkg::NUM_LANES];
    logic          corrupt   [lt_pkg::NUM_LANES][MAX_FRAMES];
    int            fault_pos [lt_pkg::NUM_LANES][MAX_FRAMES];

    assign ser_in = ser_out ^ fault;

    uart_link_tester dut0 (
        .clk (clk), .rst (rst),
        .aw_addr (aw_addr), .aw_valid (aw_valid), .aw_ready (aw_ready),
        .w_data  (w_data),  .w_valid  (w_valid),  .w_ready  (w_ready),
        .b_resp  (b_resp),  .b_valid  (b_valid),  .b_ready  (b_ready),
        .ar_addr (ar_addr), .ar_valid (ar_valid), .ar_ready (ar_ready),
        .r_data  (r_data),  .r_resp   (r_resp),   .r_valid  (r_valid),
        .r_ready (r_ready), .ser_out  (ser_out),  .ser_in   (ser_in)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // Taps 16, 14, 13 and 11 give a maximal-length sequence
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = (value << 1) | lfsr[0];
        end
    endtask

    // Expected byte of frame n in a run started at seed
    function automatic lt_pkg::byte_t ref_byte(input lt_pkg::byte_t seed, input int n);
        return lt_pkg::byte_t'((int'(seed) + n) % 256);
    endfunction

    // Expected error count of a lane after n frames of the current run
    function automatic int ref_errors(input int lane, input int n);
        int cnt;
        cnt = 0;
        for (int f = 0; f < n; f++) begin
            if (corrupt[lane][f]) cnt++;
        end
        return cnt;
    endfunction

    task automatic plan_faults(input int n);
        int pick;
        int pos;
        for (int f = 0; f < n; f++) begin
            for (int l = 0; l < lt_pkg::NUM_LANES; l++) begin
                draw_bits(2, pick);
                draw_bits(3, pos);
                corrupt[l][f]   = (pick == 0);
                fault_pos[l][f] = pos;
            end
        end
    endtask

    task automatic clear_faults();
        for (int f = 0; f < MAX_FRAMES; f++) begin
            for (int l = 0; l < lt_pkg::NUM_LANES; l++) begin
                corrupt[l][f]   = 1'b0;
                fault_pos[l][f] = 0;
            end
        end
    endtask

    // Holds b_ready low for stall cycles once the response is up
    task automatic axi_write(input lt_pkg::axil_addr_t addr, input lt_pkg::axil_data_t data,
                             input int stall);
        @(posedge clk);
        aw_addr  <= addr;
        aw_valid <= 1'b1;
        w_data   <= data;
        w_valid  <= 1'b1;
        do begin
            @(posedge clk);
        end while (!(aw_ready && w_ready));
        aw_valid <= 1'b0;
        w_valid  <= 1'b0;
        @(posedge clk);
        while (!b_valid) @(posedge clk);
        for (int i = 0; i < stall; i++) begin
            check_val("b_valid", b_valid, 1);
            check_val("b_resp", b_resp, 0);
            @(posedge clk);
        end
        b_ready <= 1'b1;
        @(posedge clk);
        b_ready <= 1'b0;
    endtask

    task automatic axi_read(input lt_pkg::axil_addr_t addr, output lt_pkg::axil_data_t data,
                            input int stall);
        lt_pkg::axil_data_t first;
        @(posedge clk);
        ar_addr  <= addr;
        ar_valid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!ar_ready);
        ar_valid <= 1'b0;
        @(posedge clk);
        while (!r_valid) @(posedge clk);
        first = r_data;
        for (int i = 0; i < stall; i++) begin
            check_val("r_valid", r_valid, 1);
            check_val("r_data", r_data, first);
            check_val("r_resp", r_resp, 0);
            @(posedge clk);
        end
        r_ready <= 1'b1;
        @(posedge clk);
        r_ready <= 1'b0;
        data = first;
    endtask

    task automatic check_counts(input int nframes);
        lt_pkg::axil_data_t rd;
        axi_read(lt_pkg::REG_ROUNDS, rd, 0);
        check_val("REG_ROUNDS", rd, exp_rounds);
        for (int l = 0; l < lt_pkg::NUM_LANES; l++) begin
            axi_read(lt_pkg::REG_ERR_BASE + 8'(4 * l), rd, 0);
            check_val($sformatf("REG_ERR%0d", l), rd, ref_errors(l, nframes));
        end
    endtask

    // Runs n frames from seed, stops the generator and waits for the last round
    task automatic run_sequence(input lt_pkg::byte_t seed, input int n);
        lt_pkg::axil_data_t rd;
        cur_seed = seed;
        run_len  = n;
        for (int l = 0; l < lt_pkg::NUM_LANES; l++) frame_idx[l] = 0;
        axi_write(lt_pkg::REG_SEED, {24'd0, seed}, 0);
        axi_write(lt_pkg::REG_CTRL, 32'h1, 0);
        wait (frame_idx[0] == n);
        axi_write(lt_pkg::REG_CTRL, 32'h0, 0);
        exp_rounds += n;
        rd = '0;
        while (rd < exp_rounds) axi_read(lt_pkg::REG_ROUNDS, rd, 0);
        check_counts(n);
    endtask

    // Each lane finds the start edge, applies the planned fault and decodes ser_out
    for (genvar g = 0; g < lt_pkg::NUM_LANES; g++) begin : g_mon
        initial begin : decode
            logic          prev;
            logic          hit;
            lt_pkg::byte_t data;
            int            idx;
            prev = 1'b1;
            forever begin
                @(posedge clk);
                if (!rst && prev && ser_out[g] === 1'b0) begin
                    idx          = frame_idx[g];
                    frame_idx[g] = idx + 1;
                    if (idx >= run_len) begin
                        fail_run($sformatf("Lane %0d sent a frame that was never requested", g));
                    end else begin
                        hit = corrupt[g][idx];
                        for (int b = 0; b < 8; b++) begin
                            repeat ((b == 0) ? 15 : 8) @(posedge clk);
                            fault[g] <= hit && (fault_pos[g][idx] == b);
                            repeat (8) @(posedge clk);
                            data[b] = ser_out[g];
                        end
                        repeat (8) @(posedge clk);
                        fault[g] <= 1'b0;
                        check_val($sformatf("ser_out[%0d] data", g), data, ref_byte(cur_seed, idx));
                        repeat (8) @(posedge clk);
                        check_val($sformatf("ser_out[%0d] parity", g), ser_out[g],
                                  ^ref_byte(cur_seed, idx));
                    end
                end
                prev = ser_out[g];
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_run($sformatf("Timeout: tests still running after %0d cycles", cycle_count));
        end
    end

    initial begin : main
        lt_pkg::axil_data_t rd;
        rst         = 1'b1;
        aw_addr     = '0;
        aw_valid    = 1'b0;
        w_data      = '0;
        w_valid     = 1'b0;
        b_ready     = 1'b0;
        ar_addr     = '0;
        ar_valid    = 1'b0;
        r_ready     = 1'b0;
        fault       = '0;
        lfsr        = 16'd5104;
        cur_seed    = '0;
        run_len     = 0;
        exp_rounds  = 0;
        cycle_count = 0;
        for (int l = 0; l < lt_pkg::NUM_LANES; l++) frame_idx[l] = 0;
        clear_faults();
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Idle lines and zeroed registers out of reset
        check_val("ser_out", ser_out, {lt_pkg::NUM_LANES{1'b1}});
        axi_read(lt_pkg::REG_CTRL, rd, 0);
        check_val("REG_CTRL", rd, 0);
        check_counts(0);

        // Slow response acceptance and unmapped reads
        axi_write(lt_pkg::REG_SEED, 32'hA5, 5);
        axi_read(lt_pkg::REG_SEED, rd, 6);
        check_val("REG_SEED", rd, 32'hA5);
        axi_read(8'h40, rd, 4);
        check_val("unmapped 0x40", rd, 0);
        axi_read(8'h0C, rd, 3);
        check_val("unmapped 0x0C", rd, 0);

        // Clean run that wraps the byte sequence past 0xFF
        run_sequence(8'hF0, N_CLEAN);

        plan_faults(N_FAULT);
        run_sequence(8'h3C, N_FAULT);

        // Clear, then count again from zero
        clear_faults();
        axi_write(lt_pkg::REG_CTRL, 32'h2, 0);
        axi_read(lt_pkg::REG_CTRL, rd, 0);
        check_val("REG_CTRL", rd, 0);
        exp_rounds = 0;
        check_counts(0);
        run_sequence(8'h7E, N_RESUME);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* rtl/error_tally.sv */
/*
  Saturating event counters for the link tester.
  One error count per lane, and one round count taken from lane 0,
  which stands for every lane since they all run in lockstep.
*/
`timescale 1ns/100ps

module error_tally (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            clear,
    input  lt_pkg::lane_mask_t                              result_valid,
    input  lt_pkg::lane_mask_t                              result_err,
    output lt_pkg::count_t                                  rounds,
    output lt_pkg::count_t [lt_pkg::NUM_LANES-1:0]          err_count
);

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            rounds    <= '0;
            err_count <= '0;
        end else begin
            if (result_valid[0] && rounds != '1) rounds <= rounds + 1'b1;
            for (int i = 0; i < lt_pkg::NUM_LANES; i++) begin
                if (result_valid[i] && result_err[i] && err_count[i] != '1) begin
                    err_count[i] <= err_count[i] + 1'b1;
                end
            end
        end
    end

endmodule

/* rtl/loopback_lane.sv */
/*
  One loopback lane: transmits each issued byte, keeps it in a small
  expected queue and checks it against the byte received back.
  Every received frame gives one result pulse with at most one error.
*/
`timescale 1ns/100ps

module loopback_lane (
    input  logic          clk,
    input  logic          rst,
    input  logic          issue_valid,
    input  lt_pkg::byte_t issue_byte,
    output logic          ser_out,
    input  logic          ser_in,
    output logic          lane_ready,
    output logic          result_valid,
    output logic          result_err
);

    logic          tx_busy;
    lt_pkg::byte_t rx_data;
    logic          rx_done;
    logic          frame_err;
    lt_pkg::byte_t queue [lt_pkg::QUEUE_DEPTH];
    logic [$clog2(lt_pkg::QUEUE_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(lt_pkg::QUEUE_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(lt_pkg::QUEUE_DEPTH+1)-1:0] fill;
    logic          pop;

    uart_tx u_tx (
        .clk      (clk),
        .rst      (rst),
        .tx_start (issue_valid),
        .tx_data  (issue_byte),
        .line     (ser_out),
        .busy     (tx_busy)
    );

    uart_rx u_rx (
        .clk       (clk),
        .rst       (rst),
        .line      (ser_in),
        .rx_data   (rx_data),
        .done      (rx_done),
        .frame_err (frame_err)
    );

    assign lane_ready = !tx_busy && (fill < lt_pkg::QUEUE_DEPTH);
    assign pop        = rx_done && (fill != '0);

    always_ff @(posedge clk) begin
        if (issue_valid) queue[wr_ptr] <= issue_byte;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            fill         <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= rx_done;
            if (issue_valid) begin
                wr_ptr <= (wr_ptr == lt_pkg::QUEUE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == lt_pkg::QUEUE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            if (issue_valid && !pop) fill <= fill + 1'b1;
            else if (pop && !issue_valid) fill <= fill - 1'b1;
        end
    end

    // A frame with nothing expected still counts as a single error
    always_ff @(posedge clk) begin
        if (rx_done) begin
            result_err <= frame_err || (fill == '0) || (rx_data != queue[rd_ptr]);
        end
    end

    a_rx_with_expected: assert property (@(posedge clk) disable iff (rst)
        rx_done |-> fill != '0);

endmodule

/* rtl/lt_regs.sv */
/*
  AXI4-Lite register slave of the link tester.
  A write needs AW and W together and all strobes set. One outstanding
  write and one outstanding read at most; every response is OKAY.
  Unmapped reads return zero, unmapped writes are dropped.
*/
`timescale 1ns/100ps

module lt_regs (
    input  logic                                   clk,
    input  logic                                   rst,
    input  lt_pkg::axil_addr_t                     aw_addr,
    input  logic                                   aw_valid,
    output logic                                   aw_ready,
    input  lt_pkg::axil_data_t                     w_data,
    input  logic                                   w_valid,
    output logic                                   w_ready,
    output logic [1:0]                             b_resp,
    output logic                                   b_valid,
    input  logic                                   b_ready,
    input  lt_pkg::axil_addr_t                     ar_addr,
    input  logic                                   ar_valid,
    output logic                                   ar_ready,
    output lt_pkg::axil_data_t                     r_data,
    output logic [1:0]                             r_resp,
    output logic                                   r_valid,
    input  logic                                   r_ready,
    input  lt_pkg::count_t                         rounds,
    input  lt_pkg::count_t [lt_pkg::NUM_LANES-1:0] err_count,
    output logic                                   run,
    output lt_pkg::byte_t                          seed,
    output logic                                   clear
);

    logic               wr_en;
    logic               rd_en;
    lt_pkg::axil_data_t rd_word;

    // Each data channel waits for its partner so both beats move together
    assign aw_ready = !b_valid && w_valid;
    assign w_ready  = !b_valid && aw_valid;
    assign ar_ready = !r_valid;
    assign wr_en    = aw_valid && w_valid && !b_valid;
    assign rd_en    = ar_valid && ar_ready;
    assign b_resp   = 2'b00;
    assign r_resp   = 2'b00;

    always_ff @(posedge clk) begin
        if (rst) begin
            run     <= 1'b0;
            seed    <= '0;
            clear   <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            clear <= 1'b0;
            if (wr_en) begin
                b_valid <= 1'b1;
                if (aw_addr == lt_pkg::REG_CTRL) begin
                    run   <= w_data[0];
                    clear <= w_data[1];
                end else if (aw_addr == lt_pkg::REG_SEED) begin
                    seed <= w_data[7:0];
                end
            end else if (b_ready) begin
                b_valid <= 1'b0;
            end
        end
    end

    always_comb begin
        rd_word = '0;
        if (ar_addr == lt_pkg::REG_CTRL) begin
            rd_word = {31'd0, run};
        end else if (ar_addr == lt_pkg::REG_SEED) begin
            rd_word = {24'd0, seed};
        end else if (ar_addr == lt_pkg::REG_ROUNDS) begin
            rd_word = {16'd0, rounds};
        end
        for (int i = 0; i < lt_pkg::NUM_LANES; i++) begin
            if (ar_addr == lt_pkg::REG_ERR_BASE + 8'(4 * i)) begin
                rd_word = {16'd0, err_count[i]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid <= 1'b0;
        end else if (rd_en) begin
            r_valid <= 1'b1;
        end else if (r_ready) begin
            r_valid <= 1'b0;
        end
    end

    // Read data is captured once and held until the beat completes
    always_ff @(posedge clk) begin
        if (rd_en) r_data <= rd_word;
    end

endmodule

/* rtl/pattern_gen.sv */
/*
  Byte sequence source shared by all lanes.
  The sequence restarts at seed on every rising run and counts up by one
  per issue. A byte goes out only in a cycle where every lane is ready.
*/
`timescale 1ns/100ps

module pattern_gen (
    input  logic               clk,
    input  logic               rst,
    input  logic               run,
    input  lt_pkg::byte_t      seed,
    input  lt_pkg::lane_mask_t lane_ready,
    output logic               issue_valid,
    output lt_pkg::byte_t      issue_byte
);

    logic          run_q;
    lt_pkg::byte_t next_byte;

    // The rising-run cycle only loads the seed, issuing starts one cycle later
    assign issue_valid = run && run_q && (&lane_ready);
    assign issue_byte  = next_byte;

    always_ff @(posedge clk) begin
        if (rst) begin
            run_q <= 1'b0;
        end else begin
            run_q <= run;
        end
    end

    always_ff @(posedge clk) begin
        if (run && !run_q) begin
            next_byte <= seed;
        end else if (issue_valid) begin
            next_byte <= next_byte + 8'd1;
        end
    end

endmodule

/* rtl/uart_link_tester.sv */
/*
  Multi-lane UART loopback link tester.
  Each ser_out must be looped back to the ser_in of the same lane
  outside this block. Control and status go through AXI4-Lite.
*/
`timescale 1ns/100ps

module uart_link_tester (
    input  logic               clk,
    input  logic               rst,
    input  lt_pkg::axil_addr_t aw_addr,
    input  logic               aw_valid,
    output logic               aw_ready,
    input  lt_pkg::axil_data_t w_data,
    input  logic               w_valid,
    output logic               w_ready,
    output logic [1:0]         b_resp,
    output logic               b_valid,
    input  logic               b_ready,
    input  lt_pkg::axil_addr_t ar_addr,
    input  logic               ar_valid,
    output logic               ar_ready,
    output lt_pkg::axil_data_t r_data,
    output logic [1:0]         r_resp,
    output logic               r_valid,
    input  logic               r_ready,
    output lt_pkg::lane_mask_t ser_out,
    input  lt_pkg::lane_mask_t ser_in
);

    logic                                   run;
    lt_pkg::byte_t                          seed;
    logic                                   clear;
    logic                                   issue_valid;
    lt_pkg::byte_t                          issue_byte;
    lt_pkg::lane_mask_t                     lane_ready;
    lt_pkg::lane_mask_t                     result_valid;
    lt_pkg::lane_mask_t                     result_err;
    lt_pkg::count_t                         rounds;
    lt_pkg::count_t [lt_pkg::NUM_LANES-1:0] err_count;

    lt_regs u_regs (
        .clk       (clk),       .rst      (rst),
        .aw_addr   (aw_addr),   .aw_valid (aw_valid), .aw_ready (aw_ready),
        .w_data    (w_data),    .w_valid  (w_valid),  .w_ready  (w_ready),
        .b_resp    (b_resp),    .b_valid  (b_valid),  .b_ready  (b_ready),
        .ar_addr   (ar_addr),   .ar_valid (ar_valid), .ar_ready (ar_ready),
        .r_data    (r_data),    .r_resp   (r_resp),   .r_valid  (r_valid),
        .r_ready   (r_ready),   .rounds   (rounds),   .err_count (err_count),
        .run       (run),       .seed     (seed),     .clear    (clear)
    );

    pattern_gen u_gen (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .seed        (seed),
        .lane_ready  (lane_ready),
        .issue_valid (issue_valid),
        .issue_byte  (issue_byte)
    );

    for (genvar i = 0; i < lt_pkg::NUM_LANES; i++) begin : g_lane
        loopback_lane u_lane (
            .clk          (clk),
            .rst          (rst),
            .issue_valid  (issue_valid),
            .issue_byte   (issue_byte),
            .ser_out      (ser_out[i]),
            .ser_in       (ser_in[i]),
            .lane_ready   (lane_ready[i]),
            .result_valid (result_valid[i]),
            .result_err   (result_err[i])
        );
    end

    error_tally u_tally (
        .clk          (clk),
        .rst          (rst),
        .clear        (clear),
        .result_valid (result_valid),
        .result_err   (result_err),
        .rounds       (rounds),
        .err_count    (err_count)
    );

endmodule

/* uart/uart_rx.sv */
/*
  UART receiver for 8E1 frames with mid-bit sampling.
  The line passes a two-flop synchronizer, so done trails the stop-bit
  centre by two clocks. A short start pulse is dropped as a glitch.
  frame_err flags a parity mismatch or a low stop bit.
*/
`timescale 1ns/100ps

module uart_rx (
    input  logic          clk,
    input  logic          rst,
    input  logic          line,
    output lt_pkg::byte_t rx_data,
    output logic          done,
    output logic          frame_err
);

    lt_pkg::rx_state_t state;
    logic [$clog2(lt_pkg::BIT_CYCLES)-1:0] cnt;
    logic [2:0]    idx;
    logic          sync1;
    logic          sync2;
    logic          sync_prev;
    lt_pkg::byte_t shreg;
    logic          par;
    logic          sample;

    assign rx_data = shreg;
    assign sample  = (cnt == lt_pkg::BIT_CYCLES - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            sync1     <= 1'b1;
            sync2     <= 1'b1;
            sync_prev <= 1'b1;
        end else begin
            sync1     <= line;
            sync2     <= sync1;
            sync_prev <= sync2;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= lt_pkg::RX_IDLE;
            cnt       <= '0;
            idx       <= '0;
            done      <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            done <= 1'b0;
            cnt  <= cnt + 1'b1;
            case (state)
                lt_pkg::RX_IDLE: begin
                    cnt <= '0;
                    if (sync_prev && !sync2) state <= lt_pkg::RX_START;
                end
                lt_pkg::RX_START: begin
                    // Half a bit in, re-align the counter to the bit centre
                    if (cnt == lt_pkg::BIT_CYCLES / 2 - 1) begin
                        cnt   <= '0;
                        idx   <= '0;
                        state <= sync2 ? lt_pkg::RX_IDLE : lt_pkg::RX_DATA;
                    end
                end
                lt_pkg::RX_DATA: begin
                    if (sample) begin
                        shreg <= {sync2, shreg[7:1]};
                        idx   <= idx + 1'b1;
                        if (idx == 3'd7) state <= lt_pkg::RX_PARITY;
                    end
                end
                lt_pkg::RX_PARITY: begin
                    if (sample) begin
                        par   <= sync2;
                        state <= lt_pkg::RX_STOP;
                    end
                end
                default: begin
                    if (sample) begin
                        done      <= 1'b1;
                        frame_err <= (^shreg ^ par) | !sync2;
                        state     <= lt_pkg::RX_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

/* uart/uart_tx.sv */
/*
  UART transmitter for one 8E1 frame, LSB first.
  tx_start is only honoured while idle; the line falls on the next cycle.
  busy stays high for FRAME_BITS bit times and drops after the stop bit.
*/
`timescale 1ns/100ps

module uart_tx (
    input  logic          clk,
    input  logic          rst,
    input  logic          tx_start,
    input  lt_pkg::byte_t tx_data,
    output logic          line,
    output logic          busy
);

    lt_pkg::tx_state_t state;
    logic [$clog2(lt_pkg::BIT_CYCLES)-1:0] cnt;
    logic [2:0]    idx;
    lt_pkg::byte_t shreg;
    logic          par;
    logic          bit_end;

    assign bit_end = (cnt == lt_pkg::BIT_CYCLES - 1);
    assign busy    = (state != lt_pkg::TX_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lt_pkg::TX_IDLE;
            cnt   <= '0;
            idx   <= '0;
            line  <= 1'b1;
        end else if (state == lt_pkg::TX_IDLE) begin
            if (tx_start) begin
                state <= lt_pkg::TX_START;
                cnt   <= '0;
                line  <= 1'b0;
            end
        end else if (!bit_end) begin
            cnt <= cnt + 1'b1;
        end else begin
            cnt <= '0;
            case (state)
                lt_pkg::TX_START: begin
                    state <= lt_pkg::TX_DATA;
                    idx   <= '0;
                    line  <= shreg[0];
                end
                lt_pkg::TX_DATA: begin
                    if (idx == 3'd7) begin
                        state <= lt_pkg::TX_PARITY;
                        line  <= par;
                    end else begin
                        idx  <= idx + 1'b1;
                        line <= shreg[0];
                    end
                end
                lt_pkg::TX_PARITY: begin
                    state <= lt_pkg::TX_STOP;
                    line  <= 1'b1;
                end
                default: state <= lt_pkg::TX_IDLE;
            endcase
        end
    end

    // Shift register always presents the next data bit in bit 0
    always_ff @(posedge clk) begin
        if (state == lt_pkg::TX_IDLE && tx_start) begin
            shreg <= tx_data;
            par   <= ^tx_data;
        end else if (bit_end && (state == lt_pkg::TX_START || state == lt_pkg::TX_DATA)) begin
            shreg <= shreg >> 1;
        end
    end

    a_no_start_while_busy: assert property (@(posedge clk) disable iff (rst)
        tx_start |-> !busy);

endmodule

/* uart_link_tester.f */
common/lt_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
rtl/pattern_gen.sv
rtl/loopback_lane.sv
rtl/error_tally.sv
rtl/lt_regs.sv
rtl/uart_link_tester.sv
dv/tb_uart_link_tester.sv
